/* files.f */
+incdir+.
cpu_pkg.sv
decode_unit.sv
exec_unit.sv
result_unit.sv
mips_int_core.sv
tb_core.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_core with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module tb_core -Mdir obj_dir -o tb_core
	./obj_dir/tb_core | tee $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* core_model.svh */
`ifndef core_model_svh
`define core_model_svh

// true for any encoding that the core executes
function automatic logic is_kept_encoding(word_t inst);
    logic [5:0] opc;
    logic [5:0] fn;
    opc = inst[31:26];
    fn  = inst[5:0];
    if (opc == 6'h00) begin
        return fn inside {6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24,
                          6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    end
    return opc inside {[6'h09:6'h0f]};
endfunction

function automatic alu_op_e pick_kept_op(int idx);
    case (idx)
        0:       return op_addu;
        1:       return op_subu;
        2:       return op_and;
        3:       return op_or;
        4:       return op_xor;
        5:       return op_nor;
        6:       return op_slt;
        7:       return op_sltu;
        8:       return op_sll;
        9:       return op_srl;
        10:      return op_sra;
        11:      return op_addiu;
        12:      return op_andi;
        13:      return op_ori;
        14:      return op_xori;
        15:      return op_slti;
        16:      return op_sltiu;
        default: return op_lui;
    endcase
endfunction

// register format writes rd, immediate format writes rt
function automatic logic is_reg_op(alu_op_e op);
    return op inside {op_addu, op_subu, op_and, op_or, op_xor, op_nor,
                      op_slt, op_sltu, op_sll, op_srl, op_sra};
endfunction

function automatic word_t encode_inst(alu_op_e op, reg_addr_t rs, reg_addr_t rt,
                                      reg_addr_t rd, logic [4:0] sh, logic [15:0] imm);
    case (op)
        op_sll:   return {6'h00, 5'd0, rt, rd, sh, 6'h00};
        op_srl:   return {6'h00, 5'd0, rt, rd, sh, 6'h02};
        op_sra:   return {6'h00, 5'd0, rt, rd, sh, 6'h03};
        op_addu:  return {6'h00, rs, rt, rd, 5'd0, 6'h21};
        op_subu:  return {6'h00, rs, rt, rd, 5'd0, 6'h23};
        op_and:   return {6'h00, rs, rt, rd, 5'd0, 6'h24};
        op_or:    return {6'h00, rs, rt, rd, 5'd0, 6'h25};
        op_xor:   return {6'h00, rs, rt, rd, 5'd0, 6'h26};
        op_nor:   return {6'h00, rs, rt, rd, 5'd0, 6'h27};
        op_slt:   return {6'h00, rs, rt, rd, 5'd0, 6'h2a};
        op_sltu:  return {6'h00, rs, rt, rd, 5'd0, 6'h2b};
        op_addiu: return {6'h09, rs, rt, imm};
        op_slti:  return {6'h0a, rs, rt, imm};
        op_sltiu: return {6'h0b, rs, rt, imm};
        op_andi:  return {6'h0c, rs, rt, imm};
        op_ori:   return {6'h0d, rs, rt, imm};
        op_xori:  return {6'h0e, rs, rt, imm};
        op_lui:   return {6'h0f, 5'd0, rt, imm};
        default:  return 32'h0;
    endcase
endfunction

function automatic word_t model_exec(alu_op_e op, word_t a, word_t b,
                                     logic [15:0] imm, logic [4:0] sh);
    word_t sx;
    word_t zx;
    sx = {{16{imm[15]}}, imm};
    zx = {16'h0000, imm};
    case (op)
        op_addu:  return a + b;
        op_subu:  return a - b;
        op_and:   return a & b;
        op_or:    return a | b;
        op_xor:   return a ^ b;
        op_nor:   return ~(a | b);
        op_slt:   return {31'd0, $signed(a) < $signed(b)};
        op_sltu:  return {31'd0, a < b};
        op_sll:   return b << sh;
        op_srl:   return b >> sh;
        op_sra:   return $unsigned($signed(b) >>> sh);
        op_addiu: return a + sx;
        op_andi:  return a & zx;
        op_ori:   return a | zx;
        op_xori:  return a ^ zx;
        op_slti:  return {31'd0, $signed(a) < $signed(sx)};
        // unsigned compare against the sign-extended immediate
        op_sltiu: return {31'd0, a < sx};
        op_lui:   return {imm, 16'h0000};
        default:  return 32'h0;
    endcase
endfunction

`endif

/* tb_core.sv */
`timescale 1ns/1ns

module tb_core;

    import cpu_pkg::*;

    localparam int n_slots = 2000;
    // slots plus reset, idle and drain cycles and some margin
    localparam int timeout_cycles = n_slots + 100;
    localparam int unsigned seed = 18068;

    // expected retirement of one issue slot
    typedef struct packed {
        logic      valid;
        logic      write;
        logic      check_data;
        word_t     pc;
        reg_addr_t dest;
        word_t     value;
    } retire_t;

    logic        aclk;
    logic        rst_n;
    logic        in_valid;
    word_t       in_pc;
    word_t       in_inst;
    word_t       debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    reg_addr_t   debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;

    word_t       model_rf [32];
    retire_t     exp_q [$];
    word_t       next_pc;
    word_t       last_pc;
    reg_addr_t   last_wnum;
    word_t       last_wdata;
    int          errors;
    int          checks;
    int          cycle_count = 0;
    int unsigned first_draw;

    `include "core_model.svh"

    mips_int_core UUT (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_pc             (in_pc),
        .in_inst           (in_inst),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire(input retire_t item);
        if (item.valid) begin
            compare_field("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen},
                          item.write ? 32'hf : 32'h0);
            compare_field("debug_wb_pc", debug_wb_pc, item.pc);
            last_pc = item.pc;
            if (item.check_data) begin
                compare_field("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum},
                              {27'h0, item.dest});
                compare_field("debug_wb_rf_wdata", debug_wb_rf_wdata, item.value);
                last_wnum  = item.dest;
                last_wdata = item.value;
            end else begin
                // wnum and wdata of an illegal encoding are undefined
                last_wnum  = debug_wb_rf_wnum;
                last_wdata = debug_wb_rf_wdata;
            end
        end else begin
            // a bubble writes nothing and the trace holds
            compare_field("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'h0);
            compare_field("debug_wb_pc", debug_wb_pc, last_pc);
            compare_field("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum}, {27'h0, last_wnum});
            compare_field("debug_wb_rf_wdata", debug_wb_rf_wdata, last_wdata);
        end
    endtask

    task automatic issue_instruction(output retire_t item);
        word_t       r;
        word_t       inst;
        alu_op_e     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        reg_addr_t   dest;
        logic [4:0]  sh;
        logic [15:0] imm;
        item       = '0;
        item.valid = 1'b1;
        item.pc    = next_pc;
        if (($urandom % 100) < 5) begin
            do begin
                inst = $urandom;
            end while (is_kept_encoding(inst));
        end else begin
            r   = $urandom;
            op  = pick_kept_op($urandom % 18);
            // r0..r7 only so dependencies are frequent
            rs  = {2'b00, r[2:0]};
            rt  = {2'b00, r[5:3]};
            rd  = {2'b00, r[8:6]};
            sh  = r[13:9];
            imm = r[31:16];
            inst = encode_inst(op, rs, rt, rd, sh, imm);
            dest = is_reg_op(op) ? rd : rt;
            item.dest       = dest;
            item.value      = model_exec(op, model_rf[rs], model_rf[rt], imm, sh);
            item.write      = (dest != 5'd0);
            item.check_data = 1'b1;
            if (item.write) begin
                model_rf[dest] = item.value;
            end
        end
        in_valid = 1'b1;
        in_pc    = next_pc;
        in_inst  = inst;
        next_pc  = next_pc + 32'd4;
    endtask

    // check the slot issued three falling edges ago and drive the next one
    task automatic step_slot(input logic issue);
        retire_t item;
        if (exp_q.size() == 3) begin
            check_retire(exp_q.pop_front());
        end
        if (issue) begin
            issue_instruction(item);
        end else begin
            item     = '0;
            in_valid = 1'b0;
            in_pc    = $urandom;
            in_inst  = $urandom;
        end
        exp_q.push_back(item);
    endtask

    initial begin
        aclk       = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        errors     = 0;
        checks     = 0;
        next_pc    = 32'hbfc0_0000;
        last_pc    = '0;
        last_wnum  = '0;
        last_wdata = '0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        first_draw = $urandom(seed);

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        step_slot(1'b0);
        // quiet trace right after reset
        repeat (3) begin
            @(negedge aclk);
            step_slot(1'b0);
        end

        for (int slot = 0; slot < n_slots; slot++) begin
            @(negedge aclk);
            step_slot(($urandom % 100) < 80);
        end

        // drain the pipeline
        repeat (3) begin
            @(negedge aclk);
            step_slot(1'b0);
        end

        $display("run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* mips_int_core.sv */
`timescale 1ns/1ns

module mips_int_core (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  cpu_pkg::word_t     in_pc,
    input  cpu_pkg::word_t     in_inst,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    import cpu_pkg::*;

    dec_uop_t  uop;
    exe_res_t  res;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    decode_unit u_decode (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .uop      (uop)
    );

    exec_unit u_exec (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .uop     (uop),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .res     (res)
    );

    result_unit u_result (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .res               (res),
        .rs_addr           (rs_addr),
        .rt_addr           (rt_addr),
        .rs_data           (rs_data),
        .rt_data           (rt_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* result_unit.sv */
`timescale 1ns/1ns

module result_unit (
    input  logic               aclk,
    input  logic               rst_n,
    input  cpu_pkg::exe_res_t  res,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    import cpu_pkg::*;

    word_t regs [reg_count];

    // r0 is hardwired
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            debug_wb_pc       <= '0;
            debug_wb_rf_wen   <= '0;
            debug_wb_rf_wnum  <= '0;
            debug_wb_rf_wdata <= '0;
        end else begin
            debug_wb_rf_wen <= '0;
            if (res.valid) begin
                if (res.write) begin
                    regs[res.dest]  <= res.value;
                    debug_wb_rf_wen <= trace_wen_all;
                end
                // trace data holds between retirements
                debug_wb_pc       <= res.pc;
                debug_wb_rf_wnum  <= res.dest;
                debug_wb_rf_wdata <= res.value;
            end
        end
    end

    a_wen_full_word: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (debug_wb_rf_wen == '0) ||
        ((debug_wb_rf_wen == trace_wen_all) && (debug_wb_rf_wnum != '0))
    );

endmodule

/* exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
    input  logic               aclk,
    input  logic               rst_n,
    input  cpu_pkg::dec_uop_t  uop,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    output cpu_pkg::exe_res_t  res
);

    import cpu_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t imm_ext;
    word_t alu_out;
    logic  zero_ext;
    logic  do_write;

    assign rs_addr = uop.rs;
    assign rt_addr = uop.rt;

    // only the direct predecessor can be missing from the register file
    assign src_a = (res.write && res.dest == uop.rs) ? res.value : rs_data;
    assign src_b = (res.write && res.dest == uop.rt) ? res.value : rt_data;

    // logical immediates are zero extended
    assign zero_ext = (uop.op == op_andi) || (uop.op == op_ori) || (uop.op == op_xori);

    assign imm_ext = zero_ext ? {{(word_w-16){1'b0}}, uop.imm16}
                              : {{(word_w-16){uop.imm16[15]}}, uop.imm16};

    always_comb begin
        case (uop.op)
            op_addu:  alu_out = src_a + src_b;
            op_subu:  alu_out = src_a - src_b;
            op_and:   alu_out = src_a & src_b;
            op_or:    alu_out = src_a | src_b;
            op_xor:   alu_out = src_a ^ src_b;
            op_nor:   alu_out = ~(src_a | src_b);
            op_slt:   alu_out = word_t'($signed(src_a) < $signed(src_b));
            op_sltu:  alu_out = word_t'(src_a < src_b);
            op_sll:   alu_out = src_b << uop.shamt;
            op_srl:   alu_out = src_b >> uop.shamt;
            op_sra:   alu_out = word_t'($signed(src_b) >>> uop.shamt);
            op_addiu: alu_out = src_a + imm_ext;
            op_andi:  alu_out = src_a & imm_ext;
            op_ori:   alu_out = src_a | imm_ext;
            op_xori:  alu_out = src_a ^ imm_ext;
            op_slti:  alu_out = word_t'($signed(src_a) < $signed(imm_ext));
            // sltiu compares unsigned against the sign-extended immediate
            op_sltiu: alu_out = word_t'(src_a < imm_ext);
            op_lui:   alu_out = imm_ext << 16;
            default:  alu_out = '0;
        endcase
    end

    // r0 and unsupported encodings retire without a write
    assign do_write = uop.valid && (uop.op != op_none) && (uop.dest != '0);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
            res.write <= 1'b0;
        end else begin
            res.valid <= uop.valid;
            res.write <= do_write;
        end
        res.pc    <= uop.pc;
        res.dest  <= uop.dest;
        res.value <= alu_out;
    end

    a_no_r0_write: assert property (
        @(posedge aclk) disable iff (!rst_n)
        res.write |-> (res.dest != '0) && !$isunknown(res.value)
    );

endmodule

/* decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
    input  logic             aclk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  cpu_pkg::word_t   in_pc,
    input  cpu_pkg::word_t   in_inst,
    output cpu_pkg::dec_uop_t uop
);

    import cpu_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs_f;
    reg_addr_t   rt_f;
    reg_addr_t   rd_f;
    logic [4:0]  shamt_f;
    logic [15:0] imm_f;
    alu_op_e     dec_op;
    reg_addr_t   dec_dest;

    assign opcode  = in_inst[31:26];
    assign rs_f    = in_inst[25:21];
    assign rt_f    = in_inst[20:16];
    assign rd_f    = in_inst[15:11];
    assign shamt_f = in_inst[10:6];
    assign funct   = in_inst[5:0];
    assign imm_f   = in_inst[15:0];

    always_comb begin
        dec_op = op_none;
        if (opcode == 6'h00) begin
            // special group, selected by funct
            case (funct)
                6'h00:   dec_op = op_sll;
                6'h02:   dec_op = op_srl;
                6'h03:   dec_op = op_sra;
                6'h21:   dec_op = op_addu;
                6'h23:   dec_op = op_subu;
                6'h24:   dec_op = op_and;
                6'h25:   dec_op = op_or;
                6'h26:   dec_op = op_xor;
                6'h27:   dec_op = op_nor;
                6'h2a:   dec_op = op_slt;
                6'h2b:   dec_op = op_sltu;
                default: dec_op = op_none;
            endcase
        end else begin
            case (opcode)
                6'h09:   dec_op = op_addiu;
                6'h0a:   dec_op = op_slti;
                6'h0b:   dec_op = op_sltiu;
                6'h0c:   dec_op = op_andi;
                6'h0d:   dec_op = op_ori;
                6'h0e:   dec_op = op_xori;
                6'h0f:   dec_op = op_lui;
                default: dec_op = op_none;
            endcase
        end
    end

    // rd for register ops, rt for immediate ops
    assign dec_dest = (opcode == 6'h00) ? rd_f : rt_f;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            uop.valid <= 1'b0;
        end else begin
            uop.valid <= in_valid;
        end
        uop.pc    <= in_pc;
        uop.op    <= dec_op;
        uop.rs    <= rs_f;
        uop.rt    <= rt_f;
        uop.dest  <= dec_dest;
        uop.imm16 <= imm_f;
        uop.shamt <= shamt_f;
    end

    a_uop_op_known: assert property (
        @(posedge aclk) disable iff (!rst_n)
        uop.valid |-> !$isunknown(uop.op)
    );

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // byte enables on the trace port for a full register write
    localparam logic [3:0] trace_wen_all = 4'hf;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // op_none marks any encoding outside the supported integer group
    typedef enum logic [4:0] {
        op_none,
        op_addu,
        op_subu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_addiu,
        op_andi,
        op_ori,
        op_xori,
        op_slti,
        op_sltiu,
        op_lui
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic        valid;
        word_t       pc;
        alu_op_e     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dest;
        logic [15:0] imm16;
        logic [4:0]  shamt;
    } dec_uop_t;

    // execute to writeback
    // write is already false for r0 and op_none
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      write;
        reg_addr_t dest;
        word_t     value;
    } exe_res_t;

endpackage
